// ==== hdl/game_config.svh ====
`ifndef GAME_CONFIG_SVH
`define GAME_CONFIG_SVH

// levels in one world, level count runs 0 .. LEVELS_PER_WORLD-1
`define LEVELS_PER_WORLD 3

// worlds in one game
`define WORLD_COUNT 3

// lives given at the start of every game
`define START_LIVES 3

// scroll ticks needed to cross one level
`define COURSE_LEN 8

// flops in each button synchronizer
`define SYNC_STAGES 2

`endif

// ==== hdl/gamePkg.sv ====
package gamePkg;

    // width shared by the level, world and lives counts
    localparam int COUNT_W  = 3;
    // widths of the two enums below
    localparam int STATE_W  = 4;
    localparam int SCREEN_W = 3;

    // game flow states
    // passing states last one cycle, wait states hold for a button
    typedef enum logic [STATE_W-1:0] {
        stTitle,
        stPlay,
        stLifeLoss,
        stLevelUp,
        stLevelUpWait,
        stWorldUp,
        stWorldUpWait,
        stWinWait,
        stLoseWait
    } gameState;

    // display screen select, encoding fixed for the video side
    typedef enum logic [SCREEN_W-1:0] {
        scrBlank   = 3'd0,
        scrTitle   = 3'd1,
        scrPlay    = 3'd2,
        scrLose    = 3'd3,
        scrWin     = 3'd4,
        scrLevelUp = 3'd5,
        scrWorldUp = 3'd6
    } screenSel;

    // progress counts
    typedef logic [COUNT_W-1:0] levelT;
    typedef logic [COUNT_W-1:0] worldT;
    typedef logic [COUNT_W-1:0] livesT;

endpackage

// ==== hdl/progressIf.sv ====
`timescale 1ns/10ps

interface progressIf;
    import gamePkg::*;

    // strobes from the game FSM, one cycle each
    logic  levelInc;
    logic  levelClr;
    logic  worldInc;
    logic  worldClr;
    logic  livesDec;
    logic  livesLoad;

    // counts and limit flags from the tracker
    levelT level;
    worldT world;
    livesT lives;
    logic  lastLevel;
    logic  lastWorld;
    logic  lastLife;

    modport fsm (
        output levelInc, levelClr, worldInc, worldClr, livesDec, livesLoad,
        input  level, world, lives, lastLevel, lastWorld, lastLife
    );

    modport tracker (
        input  levelInc, levelClr, worldInc, worldClr, livesDec, livesLoad,
        output level, world, lives, lastLevel, lastWorld, lastLife
    );

endinterface

// ==== hdl/buttonSync.sv ====
`timescale 1ns/10ps
`include "game_config.svh"

module buttonSync (
    input  logic clk,
    input  logic rst,
    input  logic startBtn,
    input  logic continueBtn,
    output logic startPress,
    output logic continuePress
);

    // bit 0 start, bit 1 continue
    logic [1:0] btnIn;
    logic [1:0] syncChain [`SYNC_STAGES];
    logic [1:0] btnPrev;
    logic [1:0] pressReg;

    assign btnIn = {continueBtn, startBtn};

    // synchronizer, stage 0 takes the raw pins
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `SYNC_STAGES; i++) begin
                syncChain[i] <= '0;
            end
        end else begin
            syncChain[0] <= btnIn;
            for (int i = 1; i < `SYNC_STAGES; i++) begin
                syncChain[i] <= syncChain[i-1];
            end
        end
    end

    // rising edge only, so a held button pulses once
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            btnPrev  <= '0;
            pressReg <= '0;
        end else begin
            btnPrev  <= syncChain[`SYNC_STAGES-1];
            pressReg <= syncChain[`SYNC_STAGES-1] & ~btnPrev;
        end
    end

    assign startPress    = pressReg[0];
    assign continuePress = pressReg[1];

endmodule

// ==== hdl/progressTracker.sv ====
`timescale 1ns/10ps
`include "game_config.svh"

module progressTracker (
    input logic     clk,
    input logic     rst,
    progressIf.tracker prog
);
    import gamePkg::*;

    // top values of each count
    localparam levelT LEVEL_MAX  = levelT'(`LEVELS_PER_WORLD - 1);
    localparam worldT WORLD_MAX  = worldT'(`WORLD_COUNT - 1);
    localparam livesT LIVES_INIT = livesT'(`START_LIVES);

    levelT levelCnt;
    worldT worldCnt;
    livesT livesCnt;

    //////////////////////////////////////////////////
    // level counter
    //////////////////////////////////////////////////

    // clear wins over increment, stops at the last level
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            levelCnt <= '0;
        end else if (prog.levelClr) begin
            levelCnt <= '0;
        end else if (prog.levelInc && (levelCnt != LEVEL_MAX)) begin
            levelCnt <= levelCnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // world counter
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            worldCnt <= '0;
        end else if (prog.worldClr) begin
            worldCnt <= '0;
        end else if (prog.worldInc && (worldCnt != WORLD_MAX)) begin
            worldCnt <= worldCnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // lives counter
    //////////////////////////////////////////////////

    // counts down, reload to the starting lives
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            livesCnt <= LIVES_INIT;
        end else if (prog.livesLoad) begin
            livesCnt <= LIVES_INIT;
        end else if (prog.livesDec && (livesCnt != '0)) begin
            livesCnt <= livesCnt - 1'b1;
        end
    end

    // counts out to the FSM and the top level
    assign prog.level = levelCnt;
    assign prog.world = worldCnt;
    assign prog.lives = livesCnt;

    // limit flags
    assign prog.lastLevel = (levelCnt == LEVEL_MAX);
    assign prog.lastWorld = (worldCnt == WORLD_MAX);
    // one life left means the next hit ends the game
    assign prog.lastLife  = (livesCnt <= livesT'(1));

endmodule

// ==== hdl/courseScroller.sv ====
`timescale 1ns/10ps
`include "game_config.svh"

module courseScroller (
    input  logic clk,
    input  logic rst,
    input  logic playerDisable,
    input  logic scrollTick,
    output logic levelDone
);

    // wide enough to hold COURSE_LEN itself
    localparam int POS_W = $clog2(`COURSE_LEN + 1);
    localparam logic [POS_W-1:0] POS_LAST = POS_W'(`COURSE_LEN - 1);

    // ticks of uninterrupted play so far
    logic [POS_W-1:0] coursePos;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            coursePos <= '0;
            levelDone <= 1'b0;
        end else begin
            // pulse by default
            levelDone <= 1'b0;
            if (playerDisable) begin
                // play suspended, course starts over
                coursePos <= '0;
            end else if (scrollTick) begin
                if (coursePos == POS_LAST) begin
                    // this tick reaches the course end
                    coursePos <= '0;
                    levelDone <= 1'b1;
                end else begin
                    coursePos <= coursePos + 1'b1;
                end
            end
        end
    end

endmodule

// ==== hdl/gameFsm.sv ====
`timescale 1ns/10ps

module gameFsm (
    input  logic             clk,
    input  logic             rst,
    input  logic             startPress,
    input  logic             continuePress,
    input  logic             playerHit,
    input  logic             levelDone,
    progressIf.fsm           prog,
    output gamePkg::screenSel screen,
    output logic             playerDisable
);
    import gamePkg::*;

    gameState curState;
    gameState nextState;

    //////////////////////////////////////////////////
    // state register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            curState <= stTitle;
        end else begin
            curState <= nextState;
        end
    end

    //////////////////////////////////////////////////
    // next state and outputs
    //////////////////////////////////////////////////

    always_comb begin
        // defaults, most states freeze the player
        nextState      = curState;
        screen         = scrBlank;
        playerDisable  = 1'b1;
        prog.levelInc  = 1'b0;
        prog.levelClr  = 1'b0;
        prog.worldInc  = 1'b0;
        prog.worldClr  = 1'b0;
        prog.livesDec  = 1'b0;
        prog.livesLoad = 1'b0;

        case (curState)
            stTitle: begin
                screen = scrTitle;
                // fresh game starts from full counts
                if (startPress) begin
                    prog.livesLoad = 1'b1;
                    prog.levelClr  = 1'b1;
                    prog.worldClr  = 1'b1;
                    nextState      = stPlay;
                end
            end
            stPlay: begin
                screen        = scrPlay;
                playerDisable = 1'b0;
                // a hit beats a level finish in the same cycle
                if (playerHit) begin
                    nextState = stLifeLoss;
                end else if (levelDone) begin
                    if (prog.lastLevel && prog.lastWorld) begin
                        nextState = stWinWait;
                    end else if (prog.lastLevel) begin
                        nextState = stWorldUp;
                    end else begin
                        nextState = stLevelUp;
                    end
                end
            end
            stLifeLoss: begin
                // keep the play screen, the hit only costs a life
                screen        = scrPlay;
                prog.livesDec = 1'b1;
                if (prog.lastLife) begin
                    nextState = stLoseWait;
                end else begin
                    nextState = stPlay;
                end
            end
            stLevelUp: begin
                screen        = scrLevelUp;
                prog.levelInc = 1'b1;
                nextState     = stLevelUpWait;
            end
            stLevelUpWait: begin
                screen = scrLevelUp;
                if (continuePress) begin
                    nextState = stPlay;
                end
            end
            stWorldUp: begin
                // new world starts at its first level
                screen        = scrWorldUp;
                prog.worldInc = 1'b1;
                prog.levelClr = 1'b1;
                nextState     = stWorldUpWait;
            end
            stWorldUpWait: begin
                screen = scrWorldUp;
                if (continuePress) begin
                    nextState = stPlay;
                end
            end
            stWinWait, stLoseWait: begin
                screen = (curState == stWinWait) ? scrWin : scrLose;
                // counts restored on the way back to title
                if (startPress) begin
                    prog.livesLoad = 1'b1;
                    prog.levelClr  = 1'b1;
                    prog.worldClr  = 1'b1;
                    nextState      = stTitle;
                end
            end
            default: begin
                nextState = stTitle;
            end
        endcase
    end

endmodule

// ==== hdl/gameCore.sv ====
`timescale 1ns/10ps

module gameCore (
    input  logic              clk,
    input  logic              rst,
    input  logic              startBtn,
    input  logic              continueBtn,
    input  logic              scrollTick,
    input  logic              playerHit,
    output gamePkg::levelT    level,
    output gamePkg::worldT    world,
    output gamePkg::livesT    lives,
    output gamePkg::screenSel screen,
    output logic              playerDisable
);

    // button pulses
    logic startPress;
    logic continuePress;
    // course end pulse
    logic levelDone;

    // progress controls and counts
    progressIf prog ();

    //////////////////////////////////////////////////
    // blocks
    //////////////////////////////////////////////////

    buttonSync uButtons (
        .clk           (clk),
        .rst           (rst),
        .startBtn      (startBtn),
        .continueBtn   (continueBtn),
        .startPress    (startPress),
        .continuePress (continuePress)
    );

    gameFsm uFsm (
        .clk           (clk),
        .rst           (rst),
        .startPress    (startPress),
        .continuePress (continuePress),
        .playerHit     (playerHit),
        .levelDone     (levelDone),
        .prog          (prog.fsm),
        .screen        (screen),
        .playerDisable (playerDisable)
    );

    progressTracker uTracker (
        .clk  (clk),
        .rst  (rst),
        .prog (prog.tracker)
    );

    courseScroller uScroller (
        .clk           (clk),
        .rst           (rst),
        .playerDisable (playerDisable),
        .scrollTick    (scrollTick),
        .levelDone     (levelDone)
    );

    // counts out for the LEDs
    assign level = prog.level;
    assign world = prog.world;
    assign lives = prog.lives;

endmodule

// ==== test/gameCore_checker.sv ====
`timescale 1ns/10ps
`include "game_config.svh"

module gameCore_checker (
    input logic              clk,
    input logic              rst,
    input gamePkg::screenSel screen,
    input gamePkg::livesT    lives,
    input logic              playerDisable
);
    import gamePkg::*;

    // failed assertions so far, read by the testbench at the end
    int failCount = 0;

    // player frozen on every screen but play
    property frozenOffPlay;
        @(posedge clk) disable iff (!rst)
            (screen != scrPlay) |-> playerDisable;
    endproperty

    // lives only ever count down from the start value
    property livesBounded;
        @(posedge clk) disable iff (!rst)
            lives <= livesT'(`START_LIVES);
    endproperty

    // first edge out of reset still on the title screen
    property titleAfterReset;
        @(posedge clk) $rose(rst) |-> (screen == scrTitle);
    endproperty

    assert property (frozenOffPlay) else begin
        $error("player enabled off the play screen");
        failCount++;
    end
    assert property (livesBounded) else begin
        $error("lives above the starting count");
        failCount++;
    end
    assert property (titleAfterReset) else begin
        $error("screen not title after reset");
        failCount++;
    end

endmodule

// ==== test/gameCoreTb.sv ====
`timescale 1ns/10ps
`include "game_config.svh"

module gameCoreTb;
    import gamePkg::*;

    // game actions applied by one table row
    typedef enum int {
        actNone, actStart, actCont, actContHold, actRun, actPartial, actHit
    } actionT;

    localparam int SETTLE_CYCLES = 3;
    localparam int WAIT_LIMIT    = 200;
    localparam int FULL          = `START_LIVES;

    logic     clk;
    logic     rst;
    logic     startBtn;
    logic     continueBtn;
    logic     scrollTick;
    logic     playerHit;
    levelT    level;
    worldT    world;
    livesT    lives;
    screenSel screen;
    logic     playerDisable;

    // table columns are row name, action, then expected screen and counts
    string    rowName  [$];
    actionT   rowAct   [$];
    screenSel rowScr   [$];
    levelT    rowLevel [$];
    worldT    rowWorld [$];
    livesT    rowLives [$];

    int errors;
    int timeouts;

    gameCore u_dut (
        .clk           (clk),
        .rst           (rst),
        .startBtn      (startBtn),
        .continueBtn   (continueBtn),
        .scrollTick    (scrollTick),
        .playerHit     (playerHit),
        .level         (level),
        .world         (world),
        .lives         (lives),
        .screen        (screen),
        .playerDisable (playerDisable)
    );

    bind gameCore gameCore_checker uChecker (
        .clk           (clk),
        .rst           (rst),
        .screen        (screen),
        .lives         (lives),
        .playerDisable (playerDisable)
    );

    // 100 ns period
    always #50 clk = ~clk;

    task automatic addRow(input string name, input actionT act, input screenSel scr,
                          input int lvl, input int wld, input int lvs);
        rowName.push_back(name);
        rowAct.push_back(act);
        rowScr.push_back(scr);
        rowLevel.push_back(levelT'(lvl));
        rowWorld.push_back(worldT'(wld));
        rowLives.push_back(livesT'(lvs));
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    // release both then raise one
    // a held press stays up afterwards
    task automatic pressButton(input bit isStart, input bit keepHeld);
        @(posedge clk);
        #5;
        startBtn    = 1'b0;
        continueBtn = 1'b0;
        @(posedge clk);
        #5;
        if (isStart) begin
            startBtn = 1'b1;
        end else begin
            continueBtn = 1'b1;
        end
        repeat (2) @(posedge clk);
        #5;
        if (!keepHeld) begin
            startBtn    = 1'b0;
            continueBtn = 1'b0;
        end
    endtask

    // one tick per cycle back to back
    task automatic scrollTicks(input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            #5;
            scrollTick = 1'b1;
        end
        @(posedge clk);
        #5;
        scrollTick = 1'b0;
    endtask

    // single cycle hit strobe
    task automatic hitPlayer();
        @(posedge clk);
        #5;
        playerHit = 1'b1;
        @(posedge clk);
        #5;
        playerHit = 1'b0;
    endtask

    task automatic applyAction(input actionT act);
        case (act)
            actStart:    pressButton(1'b1, 1'b0);
            actCont:     pressButton(1'b0, 1'b0);
            actContHold: pressButton(1'b0, 1'b1);
            actRun:      scrollTicks(`COURSE_LEN);
            actPartial:  scrollTicks(`COURSE_LEN / 2);
            actHit:      hitPlayer();
            default: begin
            end
        endcase
    endtask

    //////////////////////////////////////////////////
    // response checks
    //////////////////////////////////////////////////

    // expected screen held for a few cycles
    // counts have caught up by then
    task automatic waitSettled(input int idx);
        int stable;
        int cycles;
        stable = 0;
        cycles = 0;
        while (stable < SETTLE_CYCLES && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (screen == rowScr[idx]) begin
                stable++;
            end else begin
                stable = 0;
            end
        end
        if (stable < SETTLE_CYCLES) begin
            $display("timeout in row %s: screen never settled on %0d", rowName[idx],
                     rowScr[idx]);
            timeouts++;
        end
    endtask

    task automatic checkRow(input int idx);
        logic expDisable;
        // player runs only on a settled play screen
        expDisable = (rowScr[idx] != scrPlay);
        assert (screen == rowScr[idx]) else begin
            $display("CHECK FAILED %s screen expected %0d actual %0d", rowName[idx],
                     rowScr[idx], screen);
            errors++;
        end
        assert (level == rowLevel[idx]) else begin
            $display("CHECK FAILED %s level expected %0d actual %0d", rowName[idx],
                     rowLevel[idx], level);
            errors++;
        end
        assert (world == rowWorld[idx]) else begin
            $display("CHECK FAILED %s world expected %0d actual %0d", rowName[idx],
                     rowWorld[idx], world);
            errors++;
        end
        assert (lives == rowLives[idx]) else begin
            $display("CHECK FAILED %s lives expected %0d actual %0d", rowName[idx],
                     rowLives[idx], lives);
            errors++;
        end
        assert (playerDisable == expDisable) else begin
            $display("CHECK FAILED %s playerDisable expected %0d actual %0d",
                     rowName[idx], expDisable, playerDisable);
            errors++;
        end
    endtask

    task automatic buildTable();
        addRow("afterReset",    actNone,     scrTitle,   0, 0, FULL);
        addRow("start",         actStart,    scrPlay,    0, 0, FULL);
        addRow("level1",        actRun,      scrLevelUp, 1, 0, FULL);
        // continue stays held through the next course
        addRow("contHeld",      actContHold, scrPlay,    1, 0, FULL);
        addRow("level2Held",    actRun,      scrLevelUp, 2, 0, FULL);
        addRow("cont2",         actCont,     scrPlay,    2, 0, FULL);
        addRow("world1",        actRun,      scrWorldUp, 0, 1, FULL);
        addRow("cont3",         actCont,     scrPlay,    0, 1, FULL);
        // half a course, hit, then half again must not finish
        addRow("halfCourse",    actPartial,  scrPlay,    0, 1, FULL);
        addRow("hit1",          actHit,      scrPlay,    0, 1, FULL - 1);
        addRow("halfRestart",   actPartial,  scrPlay,    0, 1, FULL - 1);
        addRow("halfFinish",    actPartial,  scrLevelUp, 1, 1, FULL - 1);
        addRow("cont4",         actCont,     scrPlay,    1, 1, FULL - 1);
        addRow("w1Level2",      actRun,      scrLevelUp, 2, 1, FULL - 1);
        addRow("cont5",         actCont,     scrPlay,    2, 1, FULL - 1);
        addRow("world2",        actRun,      scrWorldUp, 0, 2, FULL - 1);
        addRow("cont6",         actCont,     scrPlay,    0, 2, FULL - 1);
        addRow("w2Level1",      actRun,      scrLevelUp, 1, 2, FULL - 1);
        addRow("cont7",         actCont,     scrPlay,    1, 2, FULL - 1);
        addRow("w2Level2",      actRun,      scrLevelUp, 2, 2, FULL - 1);
        addRow("cont8",         actCont,     scrPlay,    2, 2, FULL - 1);
        addRow("win",           actRun,      scrWin,     2, 2, FULL - 1);
        addRow("titleAfterWin", actStart,    scrTitle,   0, 0, FULL);
        addRow("start2",        actStart,    scrPlay,    0, 0, FULL);
        addRow("hitA",          actHit,      scrPlay,    0, 0, FULL - 1);
        addRow("hitB",          actHit,      scrPlay,    0, 0, FULL - 2);
        addRow("lose",          actHit,      scrLose,    0, 0, 0);
        addRow("titleAfterLose", actStart,   scrTitle,   0, 0, FULL);
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b0;
        startBtn    = 1'b0;
        continueBtn = 1'b0;
        scrollTick  = 1'b0;
        playerHit   = 1'b0;
        errors      = 0;
        timeouts    = 0;
        buildTable();

        // reset for 10 cycles
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b1;

        for (int i = 0; i < rowName.size(); i++) begin
            applyAction(rowAct[i]);
            waitSettled(i);
            checkRow(i);
        end

        $display("check errors %0d, timeouts %0d, assertion failures %0d", errors, timeouts,
                 u_dut.uChecker.failCount);
        if (errors == 0 && timeouts == 0 && u_dut.uChecker.failCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/gamePkg.sv
hdl/progressIf.sv
hdl/buttonSync.sv
hdl/progressTracker.sv
hdl/courseScroller.sv
hdl/gameFsm.sv
hdl/gameCore.sv
test/gameCore_checker.sv
test/gameCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f list.f --top-module gameCoreTb -o simv

# simulator status ignored here, the pass line decides
out="$(./obj_dir/simv 2>&1)" || true
echo "$out"
grep -qx '>>> PASS' <<< "$out"
